//--- build.f
sdCmdPkg.sv
cmdFrameIf.sv
crc7Gen.sv
cmdFrameBuilder.sv
cmdFrameFifo.sv
cmdLineSerializer.sv
sdCmdTop.sv
cmdLine_properties.sv
sdCmdChecker.sv
tbSdCmd.sv

//--- cmdFrameBuilder.sv
`timescale 1ns/100ps

module cmdFrameBuilder import sdCmdPkg::*; (
    input  logic        int_clk,
    input  logic        en,
    input  logic        cmdStrobe,
    input  logic [5:0]  cmdIndex,
    input  logic [31:0] cmdArg,
    output logic        cmdBusy,
    cmdFrameIf.producer frameIf
);

    logic [HeaderBits-1:0]   hdrShift;
    logic [FrameCntBits-1:0] bitCnt;
    logic                    pushReg;
    logic                    accept;
    logic                    crcShift;
    logic [CrcBits-1:0]      crc;
    sdFrame_u                frame;

    // new request only while idle
    assign accept   = cmdStrobe & ~cmdBusy;
    // busy minus the assemble cycle
    assign crcShift = cmdBusy & ~pushReg;

    // ==================================================
    // control
    // ==================================================
    always_ff @(posedge int_clk or negedge en) begin
        if (!en) begin
            cmdBusy <= 1'b0;
            pushReg <= 1'b0;
            bitCnt  <= '0;
        end else if (accept) begin
            cmdBusy <= 1'b1;
            bitCnt  <= '0;
        end else if (pushReg) begin
            // frame handed over, back to idle
            cmdBusy <= 1'b0;
            pushReg <= 1'b0;
        end else if (cmdBusy) begin
            bitCnt <= bitCnt + 1'b1;
            // last header bit goes into the crc now
            if (bitCnt == FrameCntBits'(HeaderBits - 1)) begin
                pushReg <= 1'b1;
            end
        end
    end

    // header rotates, whole again after 40 steps
    always_ff @(posedge int_clk) begin
        if (accept) begin
            hdrShift <= {2'b01, cmdIndex, cmdArg};
        end else if (crcShift) begin
            hdrShift <= {hdrShift[HeaderBits-2:0], hdrShift[HeaderBits-1]};
        end
    end

    // msb first into the crc
    crc7Gen crc7Gen_i (
        .int_clk (int_clk),
        .en      (en),
        .clear   (accept),
        .shift   (crcShift),
        .din     (hdrShift[HeaderBits-1]),
        .crc     (crc)
    );

    // ==================================================
    // frame assembly
    // ==================================================
    always_comb begin
        frame.fields.startBit = hdrShift[HeaderBits-1];
        frame.fields.dirBit   = hdrShift[HeaderBits-2];
        frame.fields.index    = hdrShift[HeaderBits-3 -: 6];
        frame.fields.arg      = hdrShift[31:0];
        frame.fields.crc      = crc;
        frame.fields.endBit   = 1'b1;
    end

    assign frameIf.pushStrobe = pushReg;
    assign frameIf.pushFrame  = frame;

endmodule

//--- cmdFrameFifo.sv
`timescale 1ns/100ps

module cmdFrameFifo import sdCmdPkg::*; (
    input  logic       int_clk,
    input  logic       en,
    output logic       fifoOverflow,
    cmdFrameIf.buffer  frameIf
);

    logic [CmdFrameBits-1:0] mem [FifoDepth];
    logic [FifoPtrBits-1:0]  wrPtr;
    logic [FifoPtrBits-1:0]  rdPtr;
    logic [FifoCntBits-1:0]  count;
    logic                    full;
    logic                    doPush;
    logic                    doPop;

    assign full   = count == FifoCntBits'(FifoDepth);
    // push into a full buffer is lost
    assign doPush = frameIf.pushStrobe & ~full;
    assign doPop  = frameIf.popStrobe & frameIf.notEmpty;

    // ==================================================
    // pointers, fill level, overflow
    // ==================================================
    always_ff @(posedge int_clk or negedge en) begin
        if (!en) begin
            wrPtr        <= '0;
            rdPtr        <= '0;
            count        <= '0;
            fifoOverflow <= 1'b0;
        end else begin
            if (doPush) begin
                wrPtr <= (wrPtr == FifoPtrBits'(FifoDepth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == FifoPtrBits'(FifoDepth - 1)) ? '0 : rdPtr + 1'b1;
            end
            if (doPush & ~doPop) begin
                count <= count + 1'b1;
            end else if (doPop & ~doPush) begin
                count <= count - 1'b1;
            end
            // sticky until reset
            if (frameIf.pushStrobe & full) begin
                fifoOverflow <= 1'b1;
            end
        end
    end

    // storage
    always_ff @(posedge int_clk) begin
        if (doPush) begin
            mem[wrPtr] <= frameIf.pushFrame.raw;
        end
    end

    // oldest entry always on the output
    assign frameIf.popFrame = mem[rdPtr];
    assign frameIf.notEmpty = count != '0;

endmodule

//--- cmdFrameIf.sv
`timescale 1ns/100ps

interface cmdFrameIf import sdCmdPkg::*;;

    // builder side, one-cycle push
    logic     pushStrobe;
    sdFrame_u pushFrame;

    // serializer side, pop only while notEmpty
    logic     popStrobe;
    sdFrame_u popFrame;
    logic     notEmpty;

    modport producer (output pushStrobe, output pushFrame);

    modport buffer (
        input  pushStrobe,
        input  pushFrame,
        input  popStrobe,
        output popFrame,
        output notEmpty
    );

    modport consumer (input popFrame, input notEmpty, output popStrobe);

endinterface

//--- cmdLineSerializer.sv
`timescale 1ns/100ps

module cmdLineSerializer import sdCmdPkg::*; (
    input  logic        int_clk,
    input  logic        en,
    input  logic        cmdIn,
    output logic        sdClk,
    output logic        cmdOut,
    output logic        cmdOe,
    output logic        respStrobe,
    output logic [5:0]  respIndex,
    output logic [31:0] respArg,
    output logic        respCrcOk,
    output logic        respTimeout,
    cmdFrameIf.consumer frameIf
);

    logic [DivBits-1:0]      divCnt;
    logic                    halfTick;
    logic                    fallTick;
    logic                    riseTick;
    logic [2:0]              state;
    logic [CmdFrameBits-1:0] txShift;
    logic [FrameCntBits-1:0] bitCnt;
    logic [TimeoutBits-1:0]  waitCnt;
    sdFrame_u                rxFrame;
    logic                    rxBit;
    logic                    crcClear;
    logic                    crcShift;
    logic [CrcBits-1:0]      rxCrc;

    // ==================================================
    // sdClk divider and edge ticks
    // ==================================================
    always_ff @(posedge int_clk or negedge en) begin
        if (!en) begin
            divCnt <= '0;
            sdClk  <= 1'b0;
        end else if (halfTick) begin
            divCnt <= '0;
            sdClk  <= ~sdClk;
        end else begin
            divCnt <= divCnt + 1'b1;
        end
    end

    assign halfTick = divCnt == DivBits'(HalfDiv - 1);
    // sdClk flips at the edge that follows a tick
    assign fallTick = halfTick & sdClk;
    assign riseTick = halfTick & ~sdClk;

    // pop exactly where the first bit is launched
    assign frameIf.popStrobe = (state == StIdle) & fallTick & frameIf.notEmpty;

    // a bit of the response is taken on this rising edge
    assign rxBit    = riseTick & ((state == StReceive) | ((state == StWaitStart) & ~cmdIn));
    // crc restarts as the line is released
    assign crcClear = (state == StSend) & fallTick & (bitCnt == '0);
    // only start bit through argument
    assign crcShift = rxBit & (bitCnt < FrameCntBits'(HeaderBits));

    crc7Gen crc7Gen_i (
        .int_clk (int_clk),
        .en      (en),
        .clear   (crcClear),
        .shift   (crcShift),
        .din     (cmdIn),
        .crc     (rxCrc)
    );

    // ==================================================
    // FSM
    // ==================================================
    always_ff @(posedge int_clk or negedge en) begin
        if (!en) begin
            state       <= StIdle;
            cmdOut      <= 1'b1;
            cmdOe       <= 1'b0;
            bitCnt      <= '0;
            waitCnt     <= '0;
            respStrobe  <= 1'b0;
            respTimeout <= 1'b0;
            respCrcOk   <= 1'b0;
        end else begin
            respStrobe  <= 1'b0;
            respTimeout <= 1'b0;
            case (state)
                StIdle: begin
                    if (frameIf.popStrobe) begin
                        cmdOe  <= 1'b1;
                        cmdOut <= frameIf.popFrame.raw[CmdFrameBits-1];
                        bitCnt <= FrameCntBits'(CmdFrameBits - 1);
                        state  <= StSend;
                    end
                end
                StSend: begin
                    // bitCnt counts the bits still to go
                    if (fallTick && bitCnt == '0) begin
                        cmdOe   <= 1'b0;
                        cmdOut  <= 1'b1;
                        waitCnt <= '0;
                        state   <= StWaitStart;
                    end else if (fallTick) begin
                        cmdOut <= txShift[CmdFrameBits-2];
                        bitCnt <= bitCnt - 1'b1;
                    end
                end
                StWaitStart: begin
                    if (rxBit) begin
                        // start bit already taken
                        bitCnt <= FrameCntBits'(1);
                        state  <= StReceive;
                    end else if (riseTick && waitCnt == TimeoutBits'(RespTimeout - 1)) begin
                        respTimeout <= 1'b1;
                        state       <= StIdle;
                    end else if (riseTick) begin
                        waitCnt <= waitCnt + 1'b1;
                    end
                end
                StReceive: begin
                    if (rxBit) begin
                        bitCnt <= bitCnt + 1'b1;
                        if (bitCnt == FrameCntBits'(CmdFrameBits - 1)) begin
                            state <= StReport;
                        end
                    end
                end
                StReport: begin
                    respStrobe <= 1'b1;
                    // card responses carry direction 0
                    respCrcOk  <= ~rxFrame.fields.startBit & ~rxFrame.fields.dirBit
                                  & (rxFrame.fields.crc == rxCrc) & rxFrame.fields.endBit;
                    state      <= StIdle;
                end
                default: state <= StIdle;
            endcase
        end
    end

    // ==================================================
    // data path
    // ==================================================
    always_ff @(posedge int_clk) begin
        if (frameIf.popStrobe) begin
            txShift <= frameIf.popFrame.raw;
        end else if (state == StSend && fallTick) begin
            txShift <= {txShift[CmdFrameBits-2:0], 1'b0};
        end
        // response shifts in msb first
        if (rxBit) begin
            rxFrame.raw <= {rxFrame.raw[CmdFrameBits-2:0], cmdIn};
        end
        if (state == StReport) begin
            respIndex <= rxFrame.fields.index;
            respArg   <= rxFrame.fields.arg;
        end
    end

endmodule

//--- cmdLine_properties.sv
`timescale 1ns/100ps

module cmdLine_properties import sdCmdPkg::*; (
    input logic int_clk,
    input logic en,
    input logic sdClk,
    input logic cmdOut,
    input logic cmdOe,
    input logic respStrobe,
    input logic respTimeout
);

    // int_clk cycles with the line driven
    int oeCycles;

    always_ff @(posedge int_clk or negedge en) begin
        if (!en) begin
            oeCycles <= 0;
        end else if (cmdOe) begin
            oeCycles <= oeCycles + 1;
        end else begin
            oeCycles <= 0;
        end
    end

    // ==================================================
    // command line timing
    // ==================================================
    // cmdOut only moves with a falling sdClk
    cmdOutOnFall: assert property (@(posedge int_clk) disable iff (!en)
        $changed(cmdOut) |-> $fell(sdClk))
        else $error("cmdOut changed away from a falling sdClk");

    // one frame is 48 sdClk periods long
    cmdOeLength: assert property (@(posedge int_clk) disable iff (!en)
        $fell(cmdOe) |-> (oeCycles == SdClkDiv * CmdFrameBits))
        else $error("cmdOe high for %0d int_clk cycles", oeCycles);

    respExclusive: assert property (@(posedge int_clk) disable iff (!en)
        !(respStrobe && respTimeout))
        else $error("respStrobe and respTimeout high together");

endmodule

bind cmdLineSerializer cmdLine_properties cmdLineProps_i (
    .int_clk     (int_clk),
    .en          (en),
    .sdClk       (sdClk),
    .cmdOut      (cmdOut),
    .cmdOe       (cmdOe),
    .respStrobe  (respStrobe),
    .respTimeout (respTimeout)
);

//--- crc7Gen.sv
`timescale 1ns/100ps

module crc7Gen import sdCmdPkg::*; (
    input  logic               int_clk,
    input  logic               en,
    input  logic               clear,
    input  logic               shift,
    input  logic               din,
    output logic [CrcBits-1:0] crc
);

    // crc state register
    // clear wins over shift
    always_ff @(posedge int_clk or negedge en) begin
        if (!en) begin
            crc <= '0;
        end else if (clear) begin
            crc <= '0;
        end else if (shift) begin
            // one data bit per enabled cycle
            crc <= crc7Next(crc, din);
        end
    end

endmodule

//--- runSim.sh
#!/bin/bash
# build with Verilator, run, then look for the pass line in the log
set -o pipefail
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tbSdCmd -f build.f -o simSdCmd &&
./obj_dir/simSdCmd 2>&1 | tee sim.log ||
{ echo "build or run error"; exit 1; }
grep -q "^sim passed$" sim.log && exit 0 || exit 1

//--- sdCmdChecker.sv
`timescale 1ns/100ps

module sdCmdChecker import sdCmdPkg::*; (
    input  logic        int_clk,
    input  logic        en,
    input  logic        cmdBusy,
    input  logic        sdClk,
    input  logic        cmdOut,
    input  logic        cmdOe,
    input  logic        respStrobe,
    input  logic [5:0]  respIndex,
    input  logic [31:0] respArg,
    input  logic        respCrcOk,
    input  logic        respTimeout,
    input  logic        fifoOverflow,
    input  logic        done,
    output int          errCount
);

    localparam int Cols       = 10;
    localparam int MaxWords   = 1 + 16 * Cols;
    // builder busy span, 40 crc shifts and the assemble cycle
    localparam int BusyCycles = 41;

    logic [31:0]             gold [MaxWords];
    int                      nTests;
    int                      accepted [$];
    logic                    expectOverflow;
    logic [CmdFrameBits-1:0] capture;
    int                      capCnt;
    int                      frameCnt;
    int                      respPtr;
    int                      busyCnt;
    int                      busyRuns;
    logic                    prevSd;
    logic                    prevOe;
    logic                    prevBusy;
    logic                    finalDone;

    function automatic logic [31:0] goldWord(input int t, input int c);
        goldWord = gold[1 + t * Cols + c];
    endfunction

    // frame layout straight from the field order
    function automatic logic [CmdFrameBits-1:0] expectedFrame(input int t);
        logic [31:0] idx;
        logic [31:0] crc;
        idx = goldWord(t, 0);
        crc = goldWord(t, 2);
        expectedFrame = {1'b0, 1'b1, idx[5:0], goldWord(t, 1), crc[6:0], 1'b1};
    endfunction

    // burst entries past one on the line plus a full fifo are lost
    task automatic buildAcceptedList();
        int burstPos;
        burstPos = 0;
        expectOverflow = 1'b0;
        for (int t = 0; t < nTests; t++) begin
            if (goldWord(t, 9) != 0) begin
                burstPos++;
            end
            if (burstPos > FifoDepth + 1) begin
                expectOverflow = 1'b1;
            end else begin
                accepted.push_back(t);
            end
        end
    endtask

    initial begin
        errCount  = 0;
        frameCnt  = 0;
        respPtr   = 0;
        capCnt    = 0;
        busyCnt   = 0;
        busyRuns  = 0;
        finalDone = 1'b0;
        $readmemh("sdCmdGolden.txt", gold);
        nTests = int'(gold[0]);
        buildAcceptedList();
    end

    // ==================================================
    // sampling on the quiet int_clk edge
    // ==================================================
    always @(negedge int_clk) begin
        if (en) begin
            // builder busy window per request
            if (cmdBusy) begin
                busyCnt++;
            end else if (prevBusy) begin
                if (busyCnt != BusyCycles) begin
                    $display("error t=%0t cmdBusy cycles expected %0d actual %0d", $time,
                             BusyCycles, busyCnt);
                    errCount++;
                end
                busyRuns++;
                busyCnt = 0;
            end
            // card side samples on rising sdClk
            if (cmdOe && sdClk && !prevSd) begin
                capture = {capture[CmdFrameBits-2:0], cmdOut};
                capCnt++;
            end
            if (!cmdOe && prevOe) begin
                if (frameCnt >= accepted.size()) begin
                    $display("unexpected extra command frame at %0t", $time);
                    errCount++;
                end else begin
                    if (capCnt != CmdFrameBits) begin
                        $display("frame at %0t had %0d bits instead of 48", $time, capCnt);
                        errCount++;
                    end
                    if (capture != expectedFrame(accepted[frameCnt])) begin
                        $display("error t=%0t cmdFrame expected %h actual %h", $time,
                                 expectedFrame(accepted[frameCnt]), capture);
                        errCount++;
                    end
                end
                frameCnt++;
                capCnt = 0;
            end
            if (respStrobe || respTimeout) begin
                checkResponse();
            end
            // closing checks once stimulus is over
            if (done && !finalDone) begin
                finalDone = 1'b1;
                if (frameCnt != accepted.size() || respPtr != accepted.size()) begin
                    $display("saw %0d frames and %0d responses, expected %0d of each",
                             frameCnt, respPtr, accepted.size());
                    errCount++;
                end
                if (busyRuns != nTests) begin
                    $display("builder took %0d requests, expected %0d", busyRuns, nTests);
                    errCount++;
                end
                if (fifoOverflow != expectOverflow) begin
                    $display("error t=%0t fifoOverflow expected %b actual %b", $time,
                             expectOverflow, fifoOverflow);
                    errCount++;
                end
            end
        end
        prevSd   = sdClk;
        prevOe   = cmdOe;
        prevBusy = cmdBusy;
    end

    task automatic checkResponse();
        int          t;
        logic [31:0] w;
        if (respPtr >= accepted.size()) begin
            $display("response end at %0t with no frame left to answer", $time);
            errCount++;
            return;
        end
        t = accepted[respPtr];
        respPtr++;
        if (goldWord(t, 8) == 0) begin
            if (respStrobe) begin
                $display("respStrobe at %0t where a timeout was expected", $time);
                errCount++;
            end
            return;
        end
        if (respTimeout) begin
            $display("respTimeout at %0t although the card answered", $time);
            errCount++;
            return;
        end
        w = goldWord(t, 3);
        if (respIndex != w[5:0]) begin
            $display("error t=%0t respIndex expected %h actual %h", $time, w[5:0], respIndex);
            errCount++;
        end
        if (respArg != goldWord(t, 4)) begin
            $display("error t=%0t respArg expected %h actual %h", $time, goldWord(t, 4),
                     respArg);
            errCount++;
        end
        w = goldWord(t, 7);
        if (respCrcOk != w[0]) begin
            $display("error t=%0t respCrcOk expected %b actual %b", $time, w[0], respCrcOk);
            errCount++;
        end
    endtask

endmodule

//--- sdCmdGolden.txt
// first word is the number of tests, then one test per line, all hex
// cmdIdx cmdArg frameCrc respIdx respArg respCrc respEnd crcOk respond burst
0C
00 00000000 4A 00 00000000 00 1 1 1 0
08 000001AA 43 08 000001AA 09 1 1 1 0
11 00000000 2A 11 00000000 60 1 1 1 0
37 00000000 32 37 00000000 7F 1 0 1 0 // response crc corrupted
3A 00000000 7E 3A 00000000 34 0 0 1 0 // response end bit low
01 00000000 7C 00 00000000 00 0 0 0 0 // card stays silent
// burst of six, the last one meets a full fifo
0C 00000000 30 0C 00000000 7A 1 1 1 1
00 00000000 4A 00 00000000 00 0 0 0 1 // silent inside the burst
08 000001AA 43 08 000001AA 09 1 1 1 1
11 00000000 2A 11 00000000 60 1 1 1 1
37 00000000 32 37 00000000 78 1 1 1 1
3A 00000000 7E 3A 00000000 34 1 1 1 1

//--- sdCmdPkg.sv
package sdCmdPkg;

    // ==================================================
    // frame geometry
    // ==================================================
    localparam int CmdFrameBits = 48;
    localparam int CrcBits      = 7;
    // start, dir, index, arg
    localparam int HeaderBits   = CmdFrameBits - CrcBits - 1;
    localparam int FrameCntBits = $clog2(CmdFrameBits);

    // ==================================================
    // sdClk divider and response wait
    // ==================================================
    // slow-rate stand-in, 4 high and 4 low
    localparam int SdClkDiv    = 8;
    localparam int HalfDiv     = SdClkDiv / 2;
    localparam int DivBits     = $clog2(HalfDiv);
    // sdClk periods to wait for a start bit
    localparam int RespTimeout = 64;
    localparam int TimeoutBits = $clog2(RespTimeout);

    // frame buffer
    localparam int FifoDepth   = 4;
    localparam int FifoPtrBits = $clog2(FifoDepth);
    localparam int FifoCntBits = $clog2(FifoDepth + 1);

    // serializer FSM encoding
    localparam logic [2:0] StIdle      = 3'd0;
    localparam logic [2:0] StSend      = 3'd1;
    localparam logic [2:0] StWaitStart = 3'd2;
    localparam logic [2:0] StReceive   = 3'd3;
    localparam logic [2:0] StReport    = 3'd4;

    // one 48-bit word, seen as a shift vector or as fields
    typedef union packed {
        logic [CmdFrameBits-1:0] raw;
        struct packed {
            logic        startBit;
            logic        dirBit;
            logic [5:0]  index;
            logic [31:0] arg;
            logic [6:0]  crc;
            logic        endBit;
        } fields;
    } sdFrame_u;

    // one step of x^7 + x^3 + 1, data bit enters at the top
    function automatic logic [CrcBits-1:0] crc7Next(input logic [CrcBits-1:0] crcIn,
                                                    input logic din);
        logic fb;
        fb = din ^ crcIn[6];
        crc7Next = {crcIn[5:3], crcIn[2] ^ fb, crcIn[1:0], fb};
    endfunction

endpackage

//--- sdCmdTop.sv
`timescale 1ns/100ps

module sdCmdTop (
    input  logic        int_clk,
    input  logic        en,
    input  logic        cmdStrobe,
    input  logic [5:0]  cmdIndex,
    input  logic [31:0] cmdArg,
    input  logic        cmdIn,
    output logic        cmdBusy,
    output logic        sdClk,
    output logic        cmdOut,
    output logic        cmdOe,
    output logic        respStrobe,
    output logic [5:0]  respIndex,
    output logic [31:0] respArg,
    output logic        respCrcOk,
    output logic        respTimeout,
    output logic        fifoOverflow
);

    // builder to fifo to serializer
    cmdFrameIf frameIf ();

    // ==================================================
    // request side
    // ==================================================
    cmdFrameBuilder cmdFrameBuilder_i (
        .int_clk   (int_clk),
        .en        (en),
        .cmdStrobe (cmdStrobe),
        .cmdIndex  (cmdIndex),
        .cmdArg    (cmdArg),
        .cmdBusy   (cmdBusy),
        .frameIf   (frameIf.producer)
    );

    // queued frames
    cmdFrameFifo cmdFrameFifo_i (
        .int_clk      (int_clk),
        .en           (en),
        .fifoOverflow (fifoOverflow),
        .frameIf      (frameIf.buffer)
    );

    // ==================================================
    // line side
    // ==================================================
    cmdLineSerializer cmdLineSerializer_i (
        .int_clk     (int_clk),
        .en          (en),
        .cmdIn       (cmdIn),
        .sdClk       (sdClk),
        .cmdOut      (cmdOut),
        .cmdOe       (cmdOe),
        .respStrobe  (respStrobe),
        .respIndex   (respIndex),
        .respArg     (respArg),
        .respCrcOk   (respCrcOk),
        .respTimeout (respTimeout),
        .frameIf     (frameIf.consumer)
    );

endmodule

//--- tbSdCmd.sv
`timescale 1ns/100ps

module tbSdCmd import sdCmdPkg::*; ;

    localparam int Cols      = 10;
    localparam int MaxWords  = 1 + 16 * Cols;
    localparam int WaitLimit = 4000;

    logic        int_clk;
    logic        en;
    logic        cmdStrobe;
    logic [5:0]  cmdIndex;
    logic [31:0] cmdArg;
    logic        cmdIn;
    logic        cmdBusy;
    logic        sdClk;
    logic        cmdOut;
    logic        cmdOe;
    logic        respStrobe;
    logic [5:0]  respIndex;
    logic [31:0] respArg;
    logic        respCrcOk;
    logic        respTimeout;
    logic        fifoOverflow;
    logic        done;
    int          chkErrors;
    int          tbErrors;
    int          nTests;
    logic [31:0] gold [MaxWords];
    logic [31:0] lcgState;
    int          accepted [$];

    sdCmdTop sdCmdTop_i (.*);

    sdCmdChecker checker_i (.errCount(chkErrors), .*);

    // 8 ns period
    always #4 int_clk = ~int_clk;

    function automatic logic [31:0] goldWord(input int t, input int c);
        goldWord = gold[1 + t * Cols + c];
    endfunction

    function automatic int nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        nextRandom = int'(lcgState[30:16]);
    endfunction

    // same drop rule as the checker, from FifoDepth
    task automatic buildAcceptedList();
        int burstPos;
        burstPos = 0;
        for (int t = 0; t < nTests; t++) begin
            if (goldWord(t, 9) != 0) begin
                burstPos++;
            end
            if (burstPos <= FifoDepth + 1) begin
                accepted.push_back(t);
            end
        end
    endtask

    // ==================================================
    // request side
    // ==================================================
    task automatic driveRequest(input int t);
        logic [31:0] w;
        w = goldWord(t, 0);
        @(negedge int_clk);
        cmdStrobe = 1'b1;
        cmdIndex  = w[5:0];
        cmdArg    = goldWord(t, 1);
        @(negedge int_clk);
        cmdStrobe = 1'b0;
    endtask

    task automatic waitBuilderIdle();
        for (int i = 0; i <= WaitLimit; i++) begin
            @(negedge int_clk);
            if (!cmdBusy) begin
                return;
            end
        end
        $display("builder stayed busy too long at %0t", $time);
        tbErrors++;
    endtask

    task automatic waitTransferEnd();
        for (int i = 0; i <= WaitLimit; i++) begin
            @(negedge int_clk);
            if (respStrobe || respTimeout) begin
                return;
            end
        end
        $display("no response strobe or timeout seen by %0t", $time);
        tbErrors++;
    endtask

    task automatic runRequests();
        for (int t = 0; t < nTests; t++) begin
            waitBuilderIdle();
            driveRequest(t);
            // single tests run to the end of the response
            if (goldWord(t, 9) == 0) begin
                waitBuilderIdle();
                waitTransferEnd();
            end
        end
    endtask

    // ==================================================
    // card model
    // ==================================================
    task automatic waitSdClkFall(output logic ok);
        logic prev;
        prev = sdClk;
        ok   = 1'b0;
        for (int i = 0; i <= WaitLimit; i++) begin
            @(negedge int_clk);
            if (prev && !sdClk) begin
                ok = 1'b1;
                return;
            end
            prev = sdClk;
        end
        $display("sdClk stopped toggling at %0t", $time);
        tbErrors++;
    endtask

    task automatic waitCmdOe(input logic level, output logic ok);
        ok = 1'b0;
        for (int i = 0; i <= WaitLimit; i++) begin
            @(negedge int_clk);
            if (cmdOe == level) begin
                ok = 1'b1;
                return;
            end
        end
        $display("cmdOe never went to %b by %0t", level, $time);
        tbErrors++;
    endtask

    task automatic runCardModel();
        logic                    ok;
        int                      t;
        int                      gap;
        logic [31:0]             w0;
        logic [31:0]             w2;
        logic [31:0]             w3;
        logic [CmdFrameBits-1:0] resp;
        foreach (accepted[k]) begin
            t = accepted[k];
            waitCmdOe(1'b1, ok);
            if (!ok) return;
            waitCmdOe(1'b0, ok);
            if (!ok) return;
            if (goldWord(t, 8) != 0) begin
                w0   = goldWord(t, 3);
                w2   = goldWord(t, 5);
                w3   = goldWord(t, 6);
                // response has direction 0
                resp = {1'b0, 1'b0, w0[5:0], goldWord(t, 4), w2[6:0], w3[0]};
                gap  = 2 + nextRandom() % 19;
                for (int g = 0; g < gap; g++) begin
                    waitSdClkFall(ok);
                    if (!ok) return;
                end
                for (int b = CmdFrameBits - 1; b >= 0; b--) begin
                    cmdIn = resp[b];
                    waitSdClkFall(ok);
                    if (!ok) return;
                end
                cmdIn = 1'b1;
            end
        end
    endtask

    initial begin
        int_clk   = 1'b0;
        en        = 1'b0;
        cmdStrobe = 1'b0;
        cmdIndex  = '0;
        cmdArg    = '0;
        cmdIn     = 1'b1;
        done      = 1'b0;
        tbErrors  = 0;
        lcgState  = 32'd51661;
        $readmemh("sdCmdGolden.txt", gold);
        nTests = int'(gold[0]);
        buildAcceptedList();
        repeat (8) @(posedge int_clk);
        @(negedge int_clk);
        en = 1'b1;
        fork
            runRequests();
            runCardModel();
        join
        // let the last response strobe settle
        repeat (16) @(negedge int_clk);
        done = 1'b1;
        repeat (2) @(negedge int_clk);
        $display("checker errors %0d, testbench errors %0d", chkErrors, tbErrors);
        if (chkErrors == 0 && tbErrors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
